//--- blk_former.f
+incdir+verilog
verilog/blk_types_pkg.sv
verilog/mem_types_pkg.sv
verilog/procb_split.sv
verilog/create_blk.sv
verilog/procb_saved_state.sv
verilog/blk_word_gen.sv
verilog/blk_former.sv
testbench/tb_blk_former.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_blk_former -f blk_former.f
out=$(./obj_dir/Vtb_blk_former || true)
echo "$out"
echo "$out" | grep -q "^TEST PASSED$"

//--- testbench/tb_blk_former.sv
`timescale 1ns/10ps
`include "sha512_config.svh"

module tb_blk_former;
	import blk_types_pkg::*;

	typedef struct packed {
		logic [63:0] data;
		logic [`THREAD_MSB:0] thread;
		logic blk_end;
		logic comp_end;
	} exp_word_t;

	logic CLK;
	logic rst;
	logic rec_wr_en;
	procb_rec_t rec;
	logic msg_wr_en;
	logic [`MEM_ADDR_MSB:0] msg_wr_addr;
	logic [63:0] msg_wr_data;
	logic busy;
	logic word_valid;
	logic [63:0] word;
	logic [`THREAD_MSB:0] word_thread;
	logic blk_end;
	logic comp_end;
	logic err;

	// image of the message memory, byte 0 of a word in the low lane
	logic [63:0] mem_img [0:(1 << (`MEM_ADDR_MSB + 1)) - 1];
	exp_word_t exp_q [$];
	int cycle_cnt;
	int cycle_limit;
	int rnd;

	blk_former u_blk_former (
		.CLK(CLK), .rst(rst), .rec_wr_en(rec_wr_en), .rec(rec),
		.msg_wr_en(msg_wr_en), .msg_wr_addr(msg_wr_addr), .msg_wr_data(msg_wr_data),
		.busy(busy), .word_valid(word_valid), .word(word), .word_thread(word_thread),
		.blk_end(blk_end), .comp_end(comp_end), .err(err)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
			report_failure($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	function automatic logic [7:0] mem_byte(input int baddr);
		int b;
		b = baddr % 2048;
		return mem_img[b / 8][(b % 8) * 8 +: 8];
	endfunction

	always @(posedge CLK) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit)
			report_failure($sformatf("run did not finish within %0d cycles", cycle_limit));
	end

	// outputs are registered, so the falling edge sees them settled
	always @(negedge CLK) begin
		exp_word_t e;
		if (!rst && !word_valid && (blk_end || comp_end))
			report_failure("blk_end or comp_end came without word_valid");
		if (!rst && word_valid) begin
			if (exp_q.size() == 0)
				report_failure("a word came out with no word expected");
			e = exp_q.pop_front();
			check_value("word", word, e.data);
			check_value("word_thread", word_thread, e.thread);
			check_value("blk_end", blk_end, e.blk_end);
			check_value("comp_end", comp_end, e.comp_end);
		end
	end

	task automatic apply_reset();
		rst = 1'b1;
		repeat (2) @(negedge CLK);
		rst = 1'b0;
		// saved-state sweep holds busy high for a few cycles
		@(negedge CLK);
		while (busy)
			@(negedge CLK);
	endtask

	task automatic load_memory();
		for (int a = 0; a < (1 << (`MEM_ADDR_MSB + 1)); a++) begin
			msg_wr_en = 1'b1;
			msg_wr_addr = a[`MEM_ADDR_MSB:0];
			msg_wr_data = {$urandom, $urandom};
			mem_img[a] = msg_wr_data;
			@(negedge CLK);
		end
		msg_wr_en = 1'b0;
	endtask

	task automatic run_comp(input int thread, input int total_len, input int n_rec,
		input int zero_idx, input bit use_stop);
		logic [7:0] msg [$];
		int cnt [0:3];
		logic [`MEM_ADDR_MSB+3:0] addr [0:3];
		int remaining;
		int slots_after;
		int lo;
		int hi;
		int nwords;
		int bit_len;
		logic [63:0] data;
		exp_word_t e;
		bit expect_err;
		remaining = total_len;
		for (int i = 0; i < n_rec; i++) begin
			slots_after = n_rec - 1 - i - ((zero_idx > i) ? 1 : 0);
			lo = remaining - 255 * slots_after;
			if (lo < 0)
				lo = 0;
			hi = (remaining < 255) ? remaining : 255;
			if (i == zero_idx)
				cnt[i] = 0;
			else
				cnt[i] = lo + int'($urandom % (hi - lo + 1));
			remaining -= cnt[i];
			// any byte address, aligned to a word or not
			addr[i] = (`MEM_ADDR_MSB + 4)'($urandom);
			for (int j = 0; j < cnt[i]; j++)
				msg.push_back(mem_byte(int'(addr[i]) + j));
		end
		if (!use_stop) begin
			bit_len = total_len * 8;
			msg.push_back(8'h80);
			while (msg.size() % 128 != 112)
				msg.push_back(8'h00);
			// upper half of the 128-bit length is always zero here
			repeat (8)
				msg.push_back(8'h00);
			for (int k = 7; k >= 0; k--)
				msg.push_back(8'(bit_len >> (8 * k)));
		end
		nwords = msg.size() / 8;
		for (int w = 0; w < nwords; w++) begin
			data = '0;
			for (int k = 0; k < 8; k++)
				data = {data[55:0], msg[8 * w + k]};
			e.data = data;
			e.thread = thread[`THREAD_MSB:0];
			e.blk_end = (w % 16 == 15);
			e.comp_end = (w == nwords - 1) && (!use_stop || total_len % 128 == 0);
			exp_q.push_back(e);
		end
		expect_err = use_stop && (total_len % 128 != 0);
		cycle_limit += 40 * n_rec + 20 * nwords;
		for (int i = 0; i < n_rec; i++) begin
			while (busy)
				@(negedge CLK);
			rec_wr_en = 1'b1;
			rec.thread_num = thread[`THREAD_MSB:0];
			rec.addr = addr[i];
			rec.cnt = 8'(cnt[i]);
			rec.fin = (i == n_rec - 1) && !use_stop;
			rec.stop = (i == n_rec - 1) && use_stop;
			rec.new_comp = (i == 0);
			@(negedge CLK);
			rec_wr_en = 1'b0;
		end
		while (busy)
			@(negedge CLK);
		while (exp_q.size() != 0)
			@(negedge CLK);
		check_value("err", err, expect_err);
	endtask

	initial begin
		int n_rec;
		int zero_idx;
		int slots;
		rst = 1'b1;
		rec_wr_en = 1'b0;
		rec = '0;
		msg_wr_en = 1'b0;
		msg_wr_addr = '0;
		msg_wr_data = '0;
		cycle_cnt = 0;
		cycle_limit = 400;
		rnd = $urandom(32'hfb9e_bf17);
		apply_reset();
		load_memory();

		// single record, then the padding edge lengths
		run_comp(0, 40, 1, -1, 1'b0);
		run_comp(1, 111, 3, 1, 1'b0);
		run_comp(2, 112, 2, -1, 1'b0);
		run_comp(3, 128, 4, 2, 1'b0);
		// stop on a block boundary, no padding
		run_comp(1, 128, 1, -1, 1'b1);

		for (int c = 0; c < 14; c++) begin
			n_rec = 1 + int'($urandom % 4);
			zero_idx = (n_rec > 1 && $urandom % 3 == 0) ? int'($urandom % n_rec) : -1;
			slots = n_rec - ((zero_idx >= 0) ? 1 : 0);
			run_comp(int'($urandom % `N_THREADS), int'($urandom % (255 * slots + 1)),
				n_rec, zero_idx, 1'b0);
		end

		// stop in the middle of a block raises err until reset
		run_comp(2, 100, 2, -1, 1'b1);
		apply_reset();
		check_value("err", err, 1'b0);
		run_comp(0, 200, 2, -1, 1'b0);

		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- verilog/blk_former.sv
`timescale 1ns/10ps
`include "sha512_config.svh"

module blk_former (
	input logic CLK,
	input logic rst,
	input logic rec_wr_en,
	input blk_types_pkg::procb_rec_t rec,
	input logic msg_wr_en,
	input logic [`MEM_ADDR_MSB:0] msg_wr_addr,
	input logic [63:0] msg_wr_data,
	output logic busy,
	output logic word_valid,
	output logic [63:0] word,
	output logic [`THREAD_MSB:0] word_thread,
	output logic blk_end,
	output logic comp_end,
	output logic err
);
	import blk_types_pkg::*;
	import mem_types_pkg::*;

	logic full, split_valid;
	split_rec_t split;
	saved_state_t load_state, save_data;
	logic save_wr_en;
	logic [`THREAD_MSB:0] save_thread_num;
	logic mem_rd_en;
	mem_rd_t mem_rd;

	procb_split u_procb_split (
		.CLK(CLK), .rst(rst), .rec_wr_en(rec_wr_en), .rec(rec), .full(full),
		.busy(busy), .split_valid(split_valid), .split(split)
	);

	create_blk u_create_blk (
		.CLK(CLK), .rst(rst), .split_valid(split_valid), .split(split),
		.load_state(load_state), .full(full), .save_wr_en(save_wr_en),
		.save_thread_num(save_thread_num), .save_data(save_data),
		.mem_rd_en(mem_rd_en), .mem_rd(mem_rd), .err(err)
	);

	procb_saved_state u_procb_saved_state (
		.CLK(CLK), .wr_en(save_wr_en), .wr_thread(save_thread_num), .wr_data(save_data),
		.rd_thread(split.thread_num), .rd_data(load_state)
	);

	blk_word_gen u_blk_word_gen (
		.CLK(CLK), .rst(rst), .msg_wr_en(msg_wr_en), .msg_wr_addr(msg_wr_addr),
		.msg_wr_data(msg_wr_data), .mem_rd_en(mem_rd_en), .mem_rd(mem_rd),
		.word_valid(word_valid), .word(word), .word_thread(word_thread),
		.blk_end(blk_end), .comp_end(comp_end)
	);

endmodule

//--- verilog/blk_types_pkg.sv
`include "sha512_config.svh"

package blk_types_pkg;

	// procb record as written by the host
	typedef struct packed {
		logic [`THREAD_MSB:0] thread_num;
		logic [`MEM_ADDR_MSB+3:0] addr;
		logic [`PROCB_CNT_MSB:0] cnt;
		logic fin;
		logic stop;
		logic new_comp;
	} procb_rec_t;

	// one word-aligned read from part one
	typedef struct packed {
		logic [`THREAD_MSB:0] thread_num;
		logic [`MEM_ADDR_MSB+3:0] addr;
		logic [3:0] len;
		logic [`PROCB_CNT_MSB:0] bytes_left_prev;
		logic bytes_end;
		logic fin;
		logic stop;
		logic blk_start;
		logic new_comp;
	} split_rec_t;

	typedef struct packed {
		logic [`PROCB_TOTAL_MSB:0] total;
		logic padded0x80;
		logic comp_active;
	} saved_state_t;

	typedef enum logic {
		BLK_OP_CONT,
		BLK_OP_END_COMP
	} blk_op_e;

	typedef enum logic [2:0] {
		PROCB,
		PAD_0x80,
		PAD0,
		TOTAL1,
		TOTAL2
	} blk_state_e;

endpackage

//--- verilog/blk_word_gen.sv
`timescale 1ns/10ps
`include "sha512_config.svh"

module blk_word_gen (
	input logic CLK,
	input logic rst,
	input logic msg_wr_en,
	input logic [`MEM_ADDR_MSB:0] msg_wr_addr,
	input logic [63:0] msg_wr_data,
	input logic mem_rd_en,
	input mem_types_pkg::mem_rd_t mem_rd,
	output logic word_valid,
	output logic [63:0] word,
	output logic [`THREAD_MSB:0] word_thread,
	output logic blk_end,
	output logic comp_end
);
	import mem_types_pkg::*;

	// byte 0 of a word sits in the low lane
	logic [63:0] msg_mem [0:(1 << (`MEM_ADDR_MSB + 1)) - 1];
	logic [63:0] rd_word;
	mem_rd_t req;
	logic req_v;
	logic [63:0] acc, acc_next;
	// bytes past the word boundary start the next word
	logic [63:0] acc_rest;
	logic [3:0] acc_cnt;
	logic [63:0] shifted;
	logic [63:0] len_bits;
	logic [7:0] bytes [0:7];

	always_ff @(posedge CLK) begin
		if (msg_wr_en)
			msg_mem[msg_wr_addr] <= msg_wr_data;
		rd_word <= msg_mem[mem_rd.addr];
		req <= mem_rd;
	end

	assign shifted = rd_word >> {req.off, 3'b000};
	// message length in bits
	assign len_bits = {{(60 - `PROCB_TOTAL_MSB){1'b0}}, req.total, 3'b000};

	always_comb begin
		int pos;
		acc_next = acc;
		acc_rest = '0;
		for (int i = 0; i < 8; i++) begin
			case (req.pad)
			PAD_NONE: bytes[i] = shifted[i*8 +: 8];
			PAD_0x80: bytes[i] = (i == 0) ? 8'h80 : 8'h00;
			PAD_TOTAL_LO: bytes[i] = len_bits[(7-i)*8 +: 8];
			default: bytes[i] = 8'h00;
			endcase
			// stream order, first byte ends up in the top lane
			pos = int'(acc_cnt) + i;
			if (i < int'(req.len)) begin
				if (pos < 8)
					acc_next[(7-pos)*8 +: 8] = bytes[i];
				else
					acc_rest[(15-pos)*8 +: 8] = bytes[i];
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			req_v <= 1'b0;
			acc_cnt <= '0;
			word_valid <= 1'b0;
			blk_end <= 1'b0;
			comp_end <= 1'b0;
		end else begin
			req_v <= mem_rd_en;
			word_valid <= 1'b0;
			blk_end <= 1'b0;
			comp_end <= 1'b0;
			if (req_v) begin
				if (acc_cnt + req.len >= 4'd8) begin
					acc <= acc_rest;
					acc_cnt <= acc_cnt + req.len - 4'd8;
					word_valid <= 1'b1;
					word <= acc_next;
					word_thread <= req.thread_num;
					blk_end <= req.blk_end;
					comp_end <= req.comp_end;
				end else begin
					acc <= acc_next;
					acc_cnt <= acc_cnt + req.len;
				end
			end
		end
	end

	// the last request of a block fills its word exactly
	a_blk_aligned: assert property (@(posedge CLK) disable iff (rst)
		req_v && req.blk_end |-> acc_cnt + req.len == 4'd8);

endmodule

//--- verilog/create_blk.sv
`timescale 1ns/10ps
`include "sha512_config.svh"

module create_blk (
	input logic CLK,
	input logic rst,
	input logic split_valid,
	input blk_types_pkg::split_rec_t split,
	input blk_types_pkg::saved_state_t load_state,
	output logic full,
	output logic save_wr_en,
	output logic [`THREAD_MSB:0] save_thread_num,
	output blk_types_pkg::saved_state_t save_data,
	output logic mem_rd_en,
	output mem_types_pkg::mem_rd_t mem_rd,
	output logic err
);
	import blk_types_pkg::*;
	import mem_types_pkg::*;

	blk_state_e state;
	logic sweeping;
	logic [`THREAD_MSB+1:0] sweep_cnt;
	logic [7:0] blk_left;
	logic [7:0] pad_left;
	logic [`PROCB_TOTAL_MSB:0] total;
	logic [`THREAD_MSB:0] thread_r;
	// leftover of a read cut at the block end
	split_rec_t carry;
	logic carry_v;

	split_rec_t cur;
	logic take, cut, blk_done, ends;
	logic [3:0] eff;
	logic [7:0] left_after;
	logic [`PROCB_TOTAL_MSB:0] base_total, total_next;
	logic [3:0] p80_len;
	logic [7:0] p80_new, p0_new;
	blk_op_e op;

	assign cur = carry_v ? carry : split;
	assign take = !sweeping && state == PROCB && (carry_v || (split_valid && !full));
	assign cut = take && ({4'b0, cur.len} > blk_left);
	assign blk_done = take && ({4'b0, cur.len} >= blk_left);
	assign ends = take && cur.bytes_end && !cut;
	assign eff = cut ? blk_left[3:0] : cur.len;
	assign left_after = blk_done ? 8'(`BLK_BYTES) : blk_left - {4'b0, eff};
	assign base_total = !cur.blk_start ? total : cur.new_comp ? '0 : load_state.total;
	assign total_next = base_total + eff;
	assign op = (ends && blk_done && cur.stop) ? BLK_OP_END_COMP : BLK_OP_CONT;

	// 0x80 request aligns the stream to 8 bytes
	assign p80_len = (pad_left[2:0] != 3'd0) ? {1'b0, pad_left[2:0]} : 4'd8;
	assign p80_new = pad_left - {4'b0, p80_len};
	assign p0_new = pad_left - 8'd8;

	function automatic mem_rd_t pad_req(input pad_e p, input logic [3:0] l,
		input logic be, input logic ce);
		mem_rd_t r;
		r = '0;
		r.thread_num = thread_r;
		r.len = l;
		r.pad = p;
		r.total = total;
		r.blk_end = be;
		r.comp_end = ce;
		return r;
	endfunction

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= PROCB;
			sweeping <= 1'b1;
			sweep_cnt <= '0;
			full <= 1'b0;
			carry_v <= 1'b0;
			mem_rd_en <= 1'b0;
			save_wr_en <= 1'b0;
			err <= 1'b0;
			blk_left <= 8'(`BLK_BYTES);
		end else begin
			mem_rd_en <= 1'b0;
			save_wr_en <= 1'b0;
			if (sweeping) begin
				full <= 1'b1;
				sweep_cnt <= sweep_cnt + 1'b1;
				if (sweep_cnt == (`THREAD_MSB+2)'(`N_THREADS)) begin
					sweeping <= 1'b0;
					full <= 1'b0;
				end else begin
					save_wr_en <= 1'b1;
					save_thread_num <= sweep_cnt[`THREAD_MSB:0];
					save_data <= '0;
				end
			end else begin
				case (state)
				PROCB: begin
					full <= cut || (ends && cur.fin);
					carry_v <= cut;
					if (take) begin
						carry <= cur;
						carry.addr <= cur.addr + blk_left[3:0];
						carry.len <= cur.len - eff;
						carry.bytes_left_prev <= cur.bytes_left_prev - eff;
						carry.blk_start <= 1'b0;
						total <= total_next;
						thread_r <= cur.thread_num;
						blk_left <= left_after;
						mem_rd_en <= cur.len != 4'd0;
						mem_rd.thread_num <= cur.thread_num;
						mem_rd.addr <= cur.addr[`MEM_ADDR_MSB+3:3];
						mem_rd.off <= cur.addr[2:0];
						mem_rd.len <= eff;
						mem_rd.pad <= PAD_NONE;
						mem_rd.total <= total_next;
						mem_rd.blk_end <= blk_done;
						mem_rd.comp_end <= op == BLK_OP_END_COMP;
						if (blk_done || ends) begin
							save_wr_en <= 1'b1;
							save_thread_num <= cur.thread_num;
							save_data.total <= total_next;
							save_data.padded0x80 <= 1'b0;
							save_data.comp_active <= !(ends && cur.stop);
						end
						if (ends && cur.fin) begin
							state <= blk_types_pkg::PAD_0x80;
							pad_left <= left_after;
						end
						// stop must end on a block boundary
						if (ends && cur.stop && left_after != 8'(`BLK_BYTES))
							err <= 1'b1;
						if (cur.blk_start && !cur.new_comp && !load_state.comp_active)
							err <= 1'b1;
					end
				end
				blk_types_pkg::PAD_0x80: begin
					mem_rd_en <= 1'b1;
					mem_rd <= pad_req(mem_types_pkg::PAD_0x80, p80_len, p80_new == 8'd0, 1'b0);
					pad_left <= p80_new;
					state <= (p80_new == 8'd16) ? TOTAL1 : PAD0;
					if (p80_new == 8'd0) begin
						// no room for the length, one more block of zeros
						pad_left <= 8'(`BLK_BYTES);
						blk_left <= 8'(`BLK_BYTES);
						save_wr_en <= 1'b1;
						save_thread_num <= thread_r;
						save_data.total <= total;
						save_data.padded0x80 <= 1'b1;
						save_data.comp_active <= 1'b1;
					end
				end
				PAD0: begin
					mem_rd_en <= 1'b1;
					mem_rd <= pad_req(PAD_ZERO, 4'd8, p0_new == 8'd0, 1'b0);
					pad_left <= p0_new;
					if (p0_new == 8'd16)
						state <= TOTAL1;
					if (p0_new == 8'd0) begin
						pad_left <= 8'(`BLK_BYTES);
						blk_left <= 8'(`BLK_BYTES);
						save_wr_en <= 1'b1;
						save_thread_num <= thread_r;
						save_data.total <= total;
						save_data.padded0x80 <= 1'b1;
						save_data.comp_active <= 1'b1;
					end
				end
				TOTAL1: begin
					mem_rd_en <= 1'b1;
					mem_rd <= pad_req(PAD_TOTAL_HI, 4'd8, 1'b0, 1'b0);
					state <= TOTAL2;
				end
				TOTAL2: begin
					mem_rd_en <= 1'b1;
					mem_rd <= pad_req(PAD_TOTAL_LO, 4'd8, 1'b1, 1'b1);
					full <= 1'b0;
					blk_left <= 8'(`BLK_BYTES);
					state <= PROCB;
					save_wr_en <= 1'b1;
					save_thread_num <= thread_r;
					save_data <= '0;
				end
				default: state <= PROCB;
				endcase
			end
		end
	end

	// no memory read, and no read from part one without back-pressure
	a_no_rd_in_sweep: assert property (@(posedge CLK) disable iff (rst)
		sweeping |-> !mem_rd_en && (!split_valid || full));
	a_blk_left: assert property (@(posedge CLK) disable iff (rst)
		state == PROCB |-> blk_left != 8'd0);

endmodule

//--- verilog/mem_types_pkg.sv
`include "sha512_config.svh"

package mem_types_pkg;

	// where the bytes of a request come from
	typedef enum logic [2:0] {
		PAD_NONE,
		PAD_0x80,
		PAD_ZERO,
		PAD_TOTAL_HI,
		PAD_TOTAL_LO
	} pad_e;

	typedef struct packed {
		logic [`THREAD_MSB:0] thread_num;
		logic [`MEM_ADDR_MSB:0] addr;
		logic [2:0] off;
		logic [3:0] len;
		pad_e pad;
		logic [`PROCB_TOTAL_MSB:0] total;
		logic blk_end;
		logic comp_end;
	} mem_rd_t;

endpackage

//--- verilog/procb_saved_state.sv
`timescale 1ns/10ps
`include "sha512_config.svh"

module procb_saved_state (
	input logic CLK,
	input logic wr_en,
	input logic [`THREAD_MSB:0] wr_thread,
	input blk_types_pkg::saved_state_t wr_data,
	input logic [`THREAD_MSB:0] rd_thread,
	output blk_types_pkg::saved_state_t rd_data
);
	import blk_types_pkg::*;

	// one entry per thread, cleared by the sweep in create_blk
	saved_state_t state_mem [0:`N_THREADS-1];

	always_ff @(posedge CLK) begin
		if (wr_en)
			state_mem[wr_thread] <= wr_data;
	end

	// read is valid in the same cycle
	assign rd_data = state_mem[rd_thread];

endmodule

//--- verilog/procb_split.sv
`timescale 1ns/10ps
`include "sha512_config.svh"

module procb_split (
	input logic CLK,
	input logic rst,
	input logic rec_wr_en,
	input blk_types_pkg::procb_rec_t rec,
	input logic full,
	output logic busy,
	output logic split_valid,
	output blk_types_pkg::split_rec_t split
);
	import blk_types_pkg::*;

	logic active;
	logic first;
	// address and count advance as reads go out
	procb_rec_t cur;
	logic [3:0] to_bnd;
	logic [3:0] rd_len;
	logic last;

	assign to_bnd = 4'd8 - {1'b0, cur.addr[2:0]};
	assign last = cur.cnt <= {{(`PROCB_CNT_MSB - 3){1'b0}}, to_bnd};
	assign rd_len = last ? cur.cnt[3:0] : to_bnd;

	// also high while create_blk sweeps or pads
	assign busy = active | full;
	assign split_valid = active;

	assign split.thread_num = cur.thread_num;
	assign split.addr = cur.addr;
	assign split.len = rd_len;
	assign split.bytes_left_prev = cur.cnt;
	assign split.bytes_end = last;
	assign split.fin = cur.fin;
	assign split.stop = cur.stop;
	assign split.blk_start = first;
	assign split.new_comp = cur.new_comp;

	always_ff @(posedge CLK) begin
		if (rst) begin
			active <= 1'b0;
			first <= 1'b0;
		end else if (rec_wr_en && !busy) begin
			active <= 1'b1;
			first <= 1'b1;
			cur <= rec;
		end else if (active && !full) begin
			cur.addr <= cur.addr + rd_len;
			cur.cnt <= cur.cnt - rd_len;
			first <= 1'b0;
			if (last)
				active <= 1'b0;
		end
	end

	a_word_bound: assert property (@(posedge CLK) disable iff (rst)
		split_valid |-> (split.len <= 4'd8) && ({1'b0, split.addr[2:0]} + split.len <= 4'd8));

endmodule

//--- verilog/sha512_config.svh
`ifndef SHA512_CONFIG_SVH
`define SHA512_CONFIG_SVH

// thread count and the width of a thread number
`define N_THREADS 4
`define THREAD_MSB 1

// 256 message words of 8 bytes
`define MEM_ADDR_MSB 7

// record byte count, up to 255
`define PROCB_CNT_MSB 7

// running byte total of one computation
`define PROCB_TOTAL_MSB 15

`define BLK_BYTES 128

`endif
